// File: files.f
+incdir+verilog
verilog/psg_pkg.sv
verilog/mix_pkg.sv
verilog/psg_mixer.sv
verilog/dma_sound_latch.sv
verilog/audio_mixer.sv
verilog/sigma_delta_dac.sv
verilog/atari_audio.sv
verif/atari_audio_checker.sv
verif/atari_audio_tb.sv

// File: Bender.yml
package:
  name: atari_audio

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/psg_pkg.sv
      - verilog/mix_pkg.sv
      - verilog/psg_mixer.sv
      - verilog/dma_sound_latch.sv
      - verilog/audio_mixer.sv
      - verilog/sigma_delta_dac.sv
      - verilog/atari_audio.sv
  - target: test
    files:
      - verif/atari_audio_checker.sv
      - verif/atari_audio_tb.sv

// File: verif/atari_audio_tb.sv
//******************************
// testbench of the audio path
// directed tests, mix model,
// dac density, timeout
//******************************

`timescale 1ns/10ps

`include "atari_audio_defines.svh"

module atari_audio_tb;
	import psg_pkg::*;
	import mix_pkg::*;

	localparam int DAC_WINDOW     = 1 << `MIX_W;    // cycles per density window
	localparam int TIMEOUT_CYCLES = 100000;          // two dac windows plus the psg and dma runs

	logic        clk_32;
	logic        xsint;
	psg_level_t  chan_a;
	psg_level_t  chan_b;
	psg_level_t  chan_c;
	logic        psg_stereo;
	dma_sample_t snd_l;
	dma_sample_t snd_r;
	logic        sample_strobe;
	mix_t        mix_l;
	mix_t        mix_r;
	logic        audio_l;
	logic        audio_r;

	int seed;
	int error_count;
	int cycle_count = 0;
	int held_l;         // last strobed dma sample as unsigned
	int held_r;

	atari_audio dut_i (
		.clk_32        ( clk_32        ),
		.xsint         ( xsint         ),
		.chan_a        ( chan_a        ),
		.chan_b        ( chan_b        ),
		.chan_c        ( chan_c        ),
		.psg_stereo    ( psg_stereo    ),
		.snd_l         ( snd_l         ),
		.snd_r         ( snd_r         ),
		.sample_strobe ( sample_strobe ),
		.mix_l         ( mix_l         ),
		.mix_r         ( mix_r         ),
		.audio_l       ( audio_l       ),
		.audio_r       ( audio_r       )
	);

	initial clk_32 = 1'b0;
	always #5 clk_32 = ~clk_32;

	always @(posedge clk_32) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// channel sum as the ym mix forms it wrapped to the sum width
	function automatic int expected_psg_sum(int a, int b, int c, bit stereo, bit left);
		int s;
		if (!stereo)
			s = a + b + c;
		else if (left)
			s = a + b;
		else
			s = c + b;
		return s % (1 << `PSG_SUM_W);
	endfunction

	// sign weight plus the value shifted up plus its top 4 bits
	function automatic int psg_term_value(int sum);
		int s;
		s = (sum - `PSG_MID + (1 << `PSG_SUM_W)) % (1 << `PSG_SUM_W);
		return ((s >= 512) ? 16384 : 0) + s * 16 + s / 64;
	endfunction

	function automatic int dma_term_value(int sample);
		int s;
		s = (sample - `DMA_MID + 256) % 256;
		return ((s >= 128) ? 16384 : 0) + s * 64 + s / 4;
	endfunction

	function automatic mix_t expected_mix(int sum, int sample);
		return mix_t'((psg_term_value(sum) + dma_term_value(sample)) % (1 << `MIX_W));
	endfunction

	// mix with the top bit flipped as an unsigned count
	function automatic int dac_offset(mix_t m);
		logic [`MIX_W-1:0] u;
		u = m;
		return (u >= 16384) ? int'(u) - 16384 : int'(u) + 16384;
	endfunction

	task automatic next_drive_point();
		@(posedge clk_32);
		#1;
	endtask

	task automatic check_mix(input string name, input mix_t expected, input mix_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_density(input string name, input int expected, input int actual);
		if (actual > expected + 1 || actual < expected - 1) begin
			error_count++;
			$display("[ERROR] %0t %s ones expected %0d actual %0d", $time, name, expected,
				actual);
		end
	endtask

	task automatic check_reset_state();
		#1;
		xsint = 1'b0;        // falling edge clears the registers before the first clock
		repeat (10) @(posedge clk_32);
		#1;
		xsint = 1'b1;
		check_mix("mix_l", '0, mix_l);
		check_mix("mix_r", '0, mix_r);
		check_bit("audio_l", 1'b0, audio_l);
		check_bit("audio_r", 1'b0, audio_r);
		held_l = `DMA_MID;   // silence after reset
		held_r = `DMA_MID;
	endtask

	// random channels every cycle with each result checked 2 cycles later
	task automatic drive_psg_sequence(input bit stereo, input int count);
		mix_t exp_l_q[$];
		mix_t exp_r_q[$];
		int   sum_l;
		int   sum_r;
		int   differ_count;
		differ_count = 0;
		for (int i = 0; i < count + 2; i++) begin
			next_drive_point();
			if (i >= 2) begin
				check_mix("mix_l", exp_l_q.pop_front(), mix_l);
				check_mix("mix_r", exp_r_q.pop_front(), mix_r);
			end
			if (i < count) begin
				chan_a = $random(seed);
				chan_b = $random(seed);
				chan_c = $random(seed);
				psg_stereo = stereo;
				sum_l = expected_psg_sum(chan_a, chan_b, chan_c, stereo, 1'b1);
				sum_r = expected_psg_sum(chan_a, chan_b, chan_c, stereo, 1'b0);
				exp_l_q.push_back(expected_mix(sum_l, held_l));
				exp_r_q.push_back(expected_mix(sum_r, held_r));
				if (exp_l_q[$] != exp_r_q[$])
					differ_count++;
			end
		end
		if (stereo && differ_count == 0) begin
			error_count++;
			$display("stereo run never produced differing left and right values");
		end
	endtask

	task automatic dma_hold_sequence();
		int   sum;
		mix_t exp_l;
		mix_t exp_r;
		next_drive_point();
		chan_a = $random(seed);
		chan_b = $random(seed);
		chan_c = $random(seed);
		psg_stereo = 1'b0;
		sum = expected_psg_sum(chan_a, chan_b, chan_c, 1'b0, 1'b1);
		repeat (2) next_drive_point();   // psg side settled
		for (int i = 0; i < 16; i++) begin
			snd_l = $random(seed);
			snd_r = $random(seed);
			sample_strobe = 1'b1;
			held_l = snd_l;
			held_r = snd_r;
			next_drive_point();
			sample_strobe = 1'b0;
			next_drive_point();
			exp_l = expected_mix(sum, held_l);
			exp_r = expected_mix(sum, held_r);
			check_mix("mix_l", exp_l, mix_l);
			check_mix("mix_r", exp_r, mix_r);
			// new samples without a strobe must not reach the mix
			for (int j = 0; j < 4; j++) begin
				snd_l = $random(seed);
				snd_r = $random(seed);
				next_drive_point();
				check_mix("mix_l", exp_l, mix_l);
				check_mix("mix_r", exp_r, mix_r);
			end
		end
	endtask

	task automatic measure_dac_density(input int a, input int b, input int c, input bit stereo,
		input int sl, input int sr, input bit negative);
		int   ones_l;
		int   ones_r;
		mix_t exp_l;
		mix_t exp_r;
		next_drive_point();
		chan_a = a;
		chan_b = b;
		chan_c = c;
		psg_stereo = stereo;
		snd_l = sl;
		snd_r = sr;
		sample_strobe = 1'b1;
		held_l = sl;
		held_r = sr;
		next_drive_point();
		sample_strobe = 1'b0;
		repeat (4) next_drive_point();   // pipeline and accumulators settle
		exp_l = expected_mix(expected_psg_sum(a, b, c, stereo, 1'b1), held_l);
		exp_r = expected_mix(expected_psg_sum(a, b, c, stereo, 1'b0), held_r);
		check_mix("mix_l", exp_l, mix_l);
		check_mix("mix_r", exp_r, mix_r);
		if (exp_l[`MIX_W-1] != negative || exp_r[`MIX_W-1] != negative) begin
			error_count++;
			$display("dac stimulus does not give the intended mix sign");
		end
		ones_l = 0;
		ones_r = 0;
		for (int i = 0; i < DAC_WINDOW; i++) begin
			next_drive_point();
			ones_l += audio_l;
			ones_r += audio_r;
		end
		check_density("audio_l", dac_offset(exp_l), ones_l);
		check_density("audio_r", dac_offset(exp_r), ones_r);
	endtask

	initial begin
		seed = 32'h8fca;
		error_count = 0;
		xsint = 1'b1;
		chan_a = '0;
		chan_b = '0;
		chan_c = '0;
		psg_stereo = 1'b0;
		snd_l = `DMA_MID;
		snd_r = `DMA_MID;
		sample_strobe = 1'b0;
		check_reset_state();
		drive_psg_sequence(1'b0, 200);   // mono
		drive_psg_sequence(1'b1, 200);   // stereo
		dma_hold_sequence();
		measure_dac_density(40, 60, 200, 1'b1, 100, 90, 1'b1);
		measure_dac_density(200, 150, 180, 1'b0, 200, 220, 1'b0);
		$display("errors: %0d", error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: verif/atari_audio_checker.sv
//******************************
// concurrent assertions on the
// audio path, bound into the top
//******************************

`timescale 1ns/10ps

module atari_audio_checker (
	input logic                 clk_32,
	input logic                 xsint,
	input logic                 sample_strobe,
	input mix_pkg::dma_signed_t ste_l,
	input mix_pkg::dma_signed_t ste_r,
	input mix_pkg::mix_t        mix_l,
	input mix_pkg::mix_t        mix_r,
	input logic                 audio_l,
	input logic                 audio_r
);

	// dac outputs stay quiet through reset
	audio_low_in_reset: assert property (@(posedge clk_32)
		!xsint |-> (!audio_l && !audio_r))
		else $error("audio bitstream high while xsint is low");

	// held dma sample only moves on a strobe
	ste_held_without_strobe: assert property (@(posedge clk_32) disable iff (!xsint)
		!sample_strobe |=> ($stable(ste_l) && $stable(ste_r)))
		else $error("ste sample changed without sample_strobe");

	mix_known_after_reset: assert property (@(posedge clk_32) disable iff (!xsint)
		!$isunknown({mix_l, mix_r}))
		else $error("mix output unknown after reset release");

endmodule

bind atari_audio atari_audio_checker checker_i (
	.clk_32        ( clk_32        ),
	.xsint         ( xsint         ),
	.sample_strobe ( sample_strobe ),
	.ste_l         ( ste_l         ),
	.ste_r         ( ste_r         ),
	.mix_l         ( mix_l         ),
	.mix_r         ( mix_r         ),
	.audio_l       ( audio_l       ),
	.audio_r       ( audio_r       )
);

// File: verilog/atari_audio.sv
//******************************
// ste audio output path top
// psg mix, dma sound, dac
//******************************

`timescale 1ns/10ps

module atari_audio (
	input  logic                 clk_32,
	input  logic                 xsint,
	// ym2149 channels
	input  psg_pkg::psg_level_t  chan_a,
	input  psg_pkg::psg_level_t  chan_b,
	input  psg_pkg::psg_level_t  chan_c,
	input  logic                 psg_stereo,
	// ste dma sound from the shifter
	input  mix_pkg::dma_sample_t snd_l,
	input  mix_pkg::dma_sample_t snd_r,
	input  logic                 sample_strobe,
	// mixed audio
	output mix_pkg::mix_t        mix_l,
	output mix_pkg::mix_t        mix_r,
	output logic                 audio_l,
	output logic                 audio_r
);
	import psg_pkg::*;
	import mix_pkg::*;

	psg_sum_t    ym_l;
	psg_sum_t    ym_r;
	dma_signed_t ste_l;
	dma_signed_t ste_r;

	psg_mixer psg_mixer_i (
		.clk_32        ( clk_32        ),
		.xsint         ( xsint         ),
		.chan_a        ( chan_a        ),
		.chan_b        ( chan_b        ),
		.chan_c        ( chan_c        ),
		.psg_stereo    ( psg_stereo    ),
		.ym_l          ( ym_l          ),
		.ym_r          ( ym_r          )
	);

	dma_sound_latch dma_sound_latch_i (
		.clk_32        ( clk_32        ),
		.xsint         ( xsint         ),
		.snd_l         ( snd_l         ),
		.snd_r         ( snd_r         ),
		.sample_strobe ( sample_strobe ),
		.ste_l         ( ste_l         ),
		.ste_r         ( ste_r         )
	);

	audio_mixer audio_mixer_i (
		.clk_32        ( clk_32        ),
		.xsint         ( xsint         ),
		.ym_l          ( ym_l          ),
		.ym_r          ( ym_r          ),
		.ste_l         ( ste_l         ),
		.ste_r         ( ste_r         ),
		.mix_l         ( mix_l         ),
		.mix_r         ( mix_r         )
	);

	sigma_delta_dac sigma_delta_dac_i (
		.clk_32        ( clk_32        ),
		.xsint         ( xsint         ),
		.mix_l         ( mix_l         ),   // also a top level output
		.mix_r         ( mix_r         ),
		.audio_l       ( audio_l       ),
		.audio_r       ( audio_r       )
	);

endmodule

// File: verilog/sigma_delta_dac.sv
//******************************
// first order sigma-delta dac
// two channels, 1 bit out
//******************************

`timescale 1ns/10ps

`include "atari_audio_defines.svh"

module sigma_delta_dac (
	input  logic          clk_32,
	input  logic          xsint,
	input  mix_pkg::mix_t mix_l,
	input  mix_pkg::mix_t mix_r,
	output logic          audio_l,    // pulse density bitstream
	output logic          audio_r
);
	import mix_pkg::*;

	dac_acc_t acc_l;
	dac_acc_t acc_r;
	dac_acc_t acc_l_next;
	dac_acc_t acc_r_next;

	// one accumulation step
	// the carry of the previous step is dropped before adding
	function automatic dac_acc_t dac_step(dac_acc_t acc, mix_t mix);
		dac_acc_t offset;
		// signed mix to offset binary, most negative value gives 0
		offset = {1'b0, ~mix[`MIX_W-1], mix[`MIX_W-2:0]};
		return {1'b0, acc[`DAC_ACC_W-2:0]} + offset;
	endfunction

	assign acc_l_next = dac_step(acc_l, mix_l);
	assign acc_r_next = dac_step(acc_r, mix_r);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			acc_l <= '0;
			acc_r <= '0;
		end else begin
			acc_l <= acc_l_next;
			acc_r <= acc_r_next;
		end
	end

	// carry of this cycle's addition
	// ones per 2^15 cycles follow the offset value
	assign audio_l = acc_l[`DAC_ACC_W-1];
	assign audio_r = acc_r[`DAC_ACC_W-1];

endmodule

// File: verilog/audio_mixer.sv
//******************************
// psg and dma sound mix
// expand to 15 bits and add
//******************************

`timescale 1ns/10ps

`include "atari_audio_defines.svh"

module audio_mixer (
	input  logic                 clk_32,
	input  logic                 xsint,
	input  psg_pkg::psg_sum_t    ym_l,
	input  psg_pkg::psg_sum_t    ym_r,
	input  mix_pkg::dma_signed_t ste_l,
	input  mix_pkg::dma_signed_t ste_r,
	output mix_pkg::mix_t        mix_l,
	output mix_pkg::mix_t        mix_r
);
	import psg_pkg::*;
	import mix_pkg::*;

	// sign bit, the sum, then its top bits to fill the low end
	function automatic mix_t psg_term(psg_sum_t sum);
		psg_sum_t s;
		s = sum - psg_sum_t'(`PSG_MID);    // wraps to two's complement
		return {s[`PSG_SUM_W-1], s, s[`PSG_SUM_W-1 -: (`MIX_W - `PSG_SUM_W - 1)]};
	endfunction

	function automatic mix_t dma_term(dma_signed_t v);
		return {v[`DMA_SAMPLE_W-1], v, v[`DMA_SAMPLE_W-1 -: (`MIX_W - `DMA_SAMPLE_W - 1)]};
	endfunction

	mix_t sum_l;
	mix_t sum_r;

	assign sum_l = psg_term(ym_l) + dma_term(ste_l);  // wraps at 15 bits
	assign sum_r = psg_term(ym_r) + dma_term(ste_r);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_l <= '0;
			mix_r <= '0;
		end else begin
			mix_l <= sum_l;
			mix_r <= sum_r;
		end
	end

endmodule

// File: verilog/dma_sound_latch.sv
//******************************
// ste dma sound sample holder
//******************************

`timescale 1ns/10ps

`include "atari_audio_defines.svh"

module dma_sound_latch (
	input  logic                 clk_32,
	input  logic                 xsint,
	input  mix_pkg::dma_sample_t snd_l,
	input  mix_pkg::dma_sample_t snd_r,
	input  logic                 sample_strobe,  // one clk_32 pulse per sample
	output mix_pkg::dma_signed_t ste_l,
	output mix_pkg::dma_signed_t ste_r
);
	import mix_pkg::*;

	dma_signed_t snd_l_signed;
	dma_signed_t snd_r_signed;

	// offset binary to two's complement
	assign snd_l_signed = snd_l - dma_sample_t'(`DMA_MID);
	assign snd_r_signed = snd_r - dma_sample_t'(`DMA_MID);

	// the sample rate is far below clk_32 so a pair is held
	// for many cycles until the shifter strobes the next one
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ste_l <= '0;             // silence
			ste_r <= '0;
		end else if (sample_strobe) begin
			ste_l <= snd_l_signed;
			ste_r <= snd_r_signed;
		end
	end

endmodule

// File: verilog/psg_mixer.sv
//******************************
// ym2149 channel mix
// mono or stereo, registered
//******************************

`timescale 1ns/10ps

`include "atari_audio_defines.svh"

module psg_mixer (
	input  logic                clk_32,
	input  logic                xsint,
	input  psg_pkg::psg_level_t chan_a,
	input  psg_pkg::psg_level_t chan_b,
	input  psg_pkg::psg_level_t chan_c,
	input  logic                psg_stereo,  // level, a+b left and c+b right
	output psg_pkg::psg_sum_t   ym_l,
	output psg_pkg::psg_sum_t   ym_r
);
	import psg_pkg::*;

	psg_sum_t a_ext;
	psg_sum_t b_ext;
	psg_sum_t c_ext;
	psg_sum_t sum_ab;
	psg_sum_t sum_cb;
	psg_sum_t sum_abc;
	psg_sum_t sum_l;
	psg_sum_t sum_r;

	// zero extend the channel levels to sum width
	assign a_ext = {{(`PSG_SUM_W - `PSG_LEVEL_W){1'b0}}, chan_a};
	assign b_ext = {{(`PSG_SUM_W - `PSG_LEVEL_W){1'b0}}, chan_b};
	assign c_ext = {{(`PSG_SUM_W - `PSG_LEVEL_W){1'b0}}, chan_c};

	assign sum_ab  = a_ext + b_ext;
	assign sum_cb  = c_ext + b_ext;
	assign sum_abc = sum_ab + c_ext;    // mono, same on both sides

	// channel b sits in the middle of the stereo image
	assign sum_l = psg_stereo ? sum_ab : sum_abc;
	assign sum_r = psg_stereo ? sum_cb : sum_abc;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ym_l <= '0;
			ym_r <= '0;
		end else begin
			ym_l <= sum_l;
			ym_r <= sum_r;
		end
	end

endmodule

// File: verilog/mix_pkg.sv
//******************************
// types of the dma sound
// samples, the mix and the dac
//******************************

`include "atari_audio_defines.svh"

package mix_pkg;

	typedef logic [`DMA_SAMPLE_W-1:0] dma_sample_t;          // offset binary from the shifter
	typedef logic signed [`DMA_SAMPLE_W-1:0] dma_signed_t;   // midpoint removed

	typedef logic signed [`MIX_W-1:0] mix_t;                 // psg plus dma per side

	// sigma-delta accumulator, top bit is the output carry
	typedef logic [`DAC_ACC_W-1:0] dac_acc_t;

endpackage

// File: verilog/psg_pkg.sv
//******************************
// types of the ym2149 channel
// levels and their sums
//******************************

`include "atari_audio_defines.svh"

package psg_pkg;

	// level as delivered by a tone/noise/envelope channel
	typedef logic [`PSG_LEVEL_W-1:0] psg_level_t;

	// unsigned channel sum, mono or one stereo side
	typedef logic [`PSG_SUM_W-1:0] psg_sum_t;

endpackage

// File: verilog/atari_audio_defines.svh
//******************************
// widths and midpoints of the
// audio path samples
//******************************

`ifndef ATARI_AUDIO_DEFINES_SVH
`define ATARI_AUDIO_DEFINES_SVH

// ym2149 side
`define PSG_LEVEL_W   8      // one channel output level
`define PSG_SUM_W     10     // sum of up to three channels
`define PSG_MID       512    // zero point of the channel sum

// ste dma sound side
`define DMA_SAMPLE_W  8
`define DMA_MID       128    // sample value for silence

// combined mix and the dac behind it
`define MIX_W         15
`define DAC_ACC_W     16     // mix width plus the carry bit

`endif
